// File: src/mul_consts.svh
/*
 * sizing and register map constants for the multiply accelerator
 * include this in any module that needs the unit count or bus addresses
 */

`ifndef MUL_CONSTS_SVH
`define MUL_CONSTS_SVH

// number of parallel multiplier units
`define MUL_NUM_UNITS 4

// shift-and-add steps per 32x32 multiply
`define MUL_ITERS 32

// result FIFO entries
`define MUL_FIFO_DEPTH 8

// word addresses on the Wishbone slave
`define MUL_ADR_A      3'd0
`define MUL_ADR_B      3'd1
`define MUL_ADR_CMD    3'd2
`define MUL_ADR_RES_LO 3'd3
`define MUL_ADR_RES_HI 3'd4
`define MUL_ADR_STATUS 3'd5

`endif

// File: src/mul_pkg.sv
/*
 * shared types for the multiply accelerator
 * opcode and unit state enums used across the design
 */

`default_nettype none

package mul_pkg;

  // opcode taken from bit 0 of the command word
  typedef enum logic {
    op_mul  = 1'b0,
    op_mulu = 1'b1
  } mul_op_e;

  // iterative unit FSM states
  // st_done covers the final sign step and the hold until drained
  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_calc = 2'd1,
    st_done = 2'd2
  } unit_state_e;

endpackage

`default_nettype wire

// File: src/mul_wb_regs.sv
/*
 * Wishbone classic slave for the multiply accelerator
 * holds operands, issues commands and returns results and status
 */

`timescale 1ns/1ps
`default_nettype none

`include "mul_consts.svh"

module mul_wb_regs
  import mul_pkg::*;
(
  input  wire                       clk,
  input  wire                       reset,
  input  wire                       wb_cyc,
  input  wire                       wb_stb,
  input  wire                       wb_we,
  input  wire [2:0]                 wb_adr,
  input  wire [31:0]                wb_dat_w,
  output logic [31:0]               wb_dat_r,
  output logic                      wb_ack,
  output logic                      issue_valid,
  output logic [31:0]               issue_a,
  output logic [31:0]               issue_b,
  output mul_op_e                   issue_op,
  input  wire                       issue_taken,
  input  wire [63:0]                res_data,
  input  wire                       res_valid,
  output logic                      res_pop,
  input  wire [3:0]                 fifo_count,
  input  wire                       fifo_full,
  input  wire [`MUL_NUM_UNITS-1:0]  unit_busy
);

  // new access seen this cycle
  // a CMD write held while its command is pending is that same access
  logic        access;
  logic        cmd_hold;
  logic        cmd_wr;
  logic [31:0] status;
  logic [31:0] rd_data;

  assign cmd_hold = wb_cyc && wb_stb && wb_we && (wb_adr == `MUL_ADR_CMD);
  assign access   = wb_cyc && wb_stb && !wb_ack && !(issue_valid && cmd_hold);
  assign cmd_wr   = access && wb_we && (wb_adr == `MUL_ADR_CMD);

  // ------------------------------
  // status word and read mux
  // ------------------------------
  always_comb begin
    status = 32'b0;
    status[0] = res_valid;
    status[1] = fifo_full;
    status[8 +: `MUL_NUM_UNITS] = unit_busy;
    status[16 +: 4] = fifo_count;
  end

  always_comb begin
    case (wb_adr)
      `MUL_ADR_A:      rd_data = issue_a;
      `MUL_ADR_B:      rd_data = issue_b;
      `MUL_ADR_CMD:    rd_data = {31'b0, issue_op};
      // empty FIFO reads back as zero
      `MUL_ADR_RES_LO: rd_data = res_valid ? res_data[31:0] : 32'b0;
      `MUL_ADR_RES_HI: rd_data = res_valid ? res_data[63:32] : 32'b0;
      `MUL_ADR_STATUS: rd_data = status;
      default:         rd_data = 32'b0;
    endcase
  end

  // ------------------------------
  // bus handshake and command issue
  // ------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      wb_ack      <= 1'b0;
      issue_valid <= 1'b0;
      issue_op    <= op_mul;
      res_pop     <= 1'b0;
    end else begin
      wb_ack  <= 1'b0;
      res_pop <= 1'b0;
      if (cmd_wr) begin
        // hold the command until dispatch takes it
        issue_valid <= 1'b1;
        issue_op    <= mul_op_e'(wb_dat_w[0]);
      end else if (access) begin
        wb_ack <= 1'b1;
        // pop rides along with the ack of a RES_HI read
        if (!wb_we && wb_adr == `MUL_ADR_RES_HI) begin
          res_pop <= res_valid;
        end
      end
      // a master that gave up on the CMD write gets no late ack
      if (issue_valid && issue_taken) begin
        issue_valid <= 1'b0;
        if (cmd_hold) begin
          wb_ack <= 1'b1;
        end
      end
    end
  end

  // operand registers and read data
  always_ff @(posedge clk) begin
    if (access && wb_we && wb_adr == `MUL_ADR_A) begin
      issue_a <= wb_dat_w;
    end
    if (access && wb_we && wb_adr == `MUL_ADR_B) begin
      issue_b <= wb_dat_w;
    end
    if (access && !wb_we) begin
      wb_dat_r <= rd_data;
    end
  end

endmodule

`default_nettype wire

// File: src/mul_dispatch.sv
/*
 * in-order round-robin issuer
 * waits for the unit at the pointer to be free, then pulses its start
 */

`timescale 1ns/1ps
`default_nettype none

`include "mul_consts.svh"

module mul_dispatch
  import mul_pkg::*;
(
  input  wire                       clk,
  input  wire                       reset,
  input  wire                       issue_valid,
  input  wire [31:0]                issue_a,
  input  wire [31:0]                issue_b,
  input  mul_op_e                   issue_op,
  input  wire [`MUL_NUM_UNITS-1:0]  unit_busy,
  output logic                      issue_taken,
  output logic [`MUL_NUM_UNITS-1:0] unit_start,
  output logic [31:0]               unit_a,
  output logic [31:0]               unit_b,
  output mul_op_e                   unit_op
);

  localparam int PTR_W = $clog2(`MUL_NUM_UNITS);

  logic [PTR_W-1:0] ptr;
  logic             unit_free;

  // only the pointed-to unit is considered
  assign unit_free   = !unit_busy[ptr];
  assign issue_taken = issue_valid && unit_free;

  always_ff @(posedge clk) begin
    if (reset) begin
      ptr        <= '0;
      unit_start <= '0;
    end else begin
      unit_start <= '0;
      if (issue_taken) begin
        unit_start[ptr] <= 1'b1;
        // strict rotation keeps results in issue order
        ptr <= (ptr == PTR_W'(`MUL_NUM_UNITS - 1)) ? '0 : ptr + 1'b1;
      end
    end
  end

  // operands broadcast to all units alongside the start pulse
  always_ff @(posedge clk) begin
    if (issue_taken) begin
      unit_a  <= issue_a;
      unit_b  <= issue_b;
      unit_op <= issue_op;
    end
  end

endmodule

`default_nettype wire

// File: src/mul_iter_unit.sv
/*
 * iterative 32x32 shift-and-add multiplier with a 64-bit product
 * signed or unsigned per opcode; holds done until the collector takes it
 */

`timescale 1ns/1ps
`default_nettype none

`include "mul_consts.svh"

module mul_iter_unit
  import mul_pkg::*;
(
  input  wire         clk,
  input  wire         reset,
  input  wire         start,
  input  wire [31:0]  a,
  input  wire [31:0]  b,
  input  mul_op_e     op,
  input  wire         taken,
  output logic        busy,
  output logic        done,
  output logic [63:0] result
);

  unit_state_e state;

  logic [4:0]  cnt;
  // set once the final sign has been applied in st_done
  logic        fin;

  logic [63:0] a_reg;
  logic [31:0] b_reg;
  logic [63:0] acc;
  logic        sign_reg;

  logic [31:0] mag_a;
  logic [31:0] mag_b;
  logic        is_signed;

  // ------------------------------
  // operand conditioning
  // ------------------------------
  assign is_signed = (op == op_mul);

  // magnitudes for signed ops
  // 0x80000000 maps onto itself which is 2^31 unsigned
  assign mag_a = (is_signed && a[31]) ? (~a + 32'd1) : a;
  assign mag_b = (is_signed && b[31]) ? (~b + 32'd1) : b;

  // ------------------------------
  // control FSM
  // ------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      cnt   <= 5'd0;
      fin   <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (start) begin
            state <= st_calc;
            cnt   <= 5'(`MUL_ITERS - 1);
            fin   <= 1'b0;
          end
        end
        st_calc: begin
          cnt <= cnt - 5'd1;
          // last iteration
          if (cnt == 5'd0) begin
            state <= st_done;
          end
        end
        st_done: begin
          // first cycle here is the sign step
          if (!fin) begin
            fin <= 1'b1;
          end else if (taken) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // ------------------------------
  // datapath
  // ------------------------------
  always_ff @(posedge clk) begin
    if (state == st_idle && start) begin
      a_reg    <= {32'b0, mag_a};
      b_reg    <= mag_b;
      acc      <= 64'b0;
      sign_reg <= is_signed && (a[31] ^ b[31]);
    end else if (state == st_calc) begin
      // add shifted A when the current multiplier bit is set
      if (b_reg[0]) begin
        acc <= acc + a_reg;
      end
      a_reg <= a_reg << 1;
      b_reg <= b_reg >> 1;
    end else if (state == st_done && !fin && sign_reg) begin
      acc <= ~acc + 64'd1;
    end
  end

  assign busy   = (state != st_idle);
  assign done   = (state == st_done) && fin;
  assign result = acc;

endmodule

`default_nettype wire

// File: src/mul_collect.sv
/*
 * in-order drain of finished multiplier units into the result FIFO
 * FIFO head is presented to the bus slave and popped on RES_HI reads
 */

`timescale 1ns/1ps
`default_nettype none

`include "mul_consts.svh"

module mul_collect (
  input  wire                             clk,
  input  wire                             reset,
  input  wire [`MUL_NUM_UNITS-1:0]        unit_done,
  input  wire [`MUL_NUM_UNITS-1:0][63:0]  unit_result,
  input  wire                             res_pop,
  output logic [`MUL_NUM_UNITS-1:0]       unit_taken,
  output logic [63:0]                     res_data,
  output logic                            res_valid,
  output logic [3:0]                      fifo_count,
  output logic                            fifo_full
);

  localparam int PTR_W = $clog2(`MUL_NUM_UNITS);
  localparam int AW    = $clog2(`MUL_FIFO_DEPTH);

  logic [PTR_W-1:0]  drain_ptr;
  logic [AW-1:0]     wr_ptr;
  logic [AW-1:0]     rd_ptr;
  logic [63:0]       mem [`MUL_FIFO_DEPTH];
  logic              push;
  logic              pop;

  // ------------------------------
  // drain side
  // ------------------------------
  // only the pointed-to unit may drain so order follows dispatch
  always_comb begin
    unit_taken = '0;
    if (unit_done[drain_ptr] && !fifo_full) begin
      unit_taken[drain_ptr] = 1'b1;
    end
  end

  assign push = |unit_taken;
  assign pop  = res_pop && res_valid;

  // ------------------------------
  // result FIFO
  // ------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      drain_ptr  <= '0;
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      fifo_count <= 4'd0;
    end else begin
      if (push) begin
        drain_ptr <= (drain_ptr == PTR_W'(`MUL_NUM_UNITS - 1)) ? '0 : drain_ptr + 1'b1;
        wr_ptr    <= (wr_ptr == AW'(`MUL_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == AW'(`MUL_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // push and pop together leave the count unchanged
      case ({push, pop})
        2'b10:   fifo_count <= fifo_count + 4'd1;
        2'b01:   fifo_count <= fifo_count - 4'd1;
        default: fifo_count <= fifo_count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= unit_result[drain_ptr];
    end
  end

  assign res_data  = mem[rd_ptr];
  assign res_valid = (fifo_count != 4'd0);
  assign fifo_full = (fifo_count == 4'(`MUL_FIFO_DEPTH));

endmodule

`default_nettype wire

// File: src/mul_top.sv
/*
 * multiply accelerator top level on a Wishbone classic slave port
 * bus slave, dispatcher, parallel iterative units and result collector
 */

`timescale 1ns/1ps
`default_nettype none

`include "mul_consts.svh"

module mul_top
  import mul_pkg::*;
(
  input  wire         clk,
  input  wire         reset,
  input  wire         wb_cyc,
  input  wire         wb_stb,
  input  wire         wb_we,
  input  wire [2:0]   wb_adr,
  input  wire [31:0]  wb_dat_w,
  output logic [31:0] wb_dat_r,
  output logic        wb_ack
);

  // slave to dispatch
  logic        issue_valid;
  logic        issue_taken;
  logic [31:0] issue_a;
  logic [31:0] issue_b;
  mul_op_e     issue_op;

  // dispatch to units
  logic [`MUL_NUM_UNITS-1:0] unit_start;
  logic [31:0]               unit_a;
  logic [31:0]               unit_b;
  mul_op_e                   unit_op;

  // units to collect
  logic [`MUL_NUM_UNITS-1:0]       unit_busy;
  logic [`MUL_NUM_UNITS-1:0]       unit_done;
  logic [`MUL_NUM_UNITS-1:0]       unit_taken;
  logic [`MUL_NUM_UNITS-1:0][63:0] unit_result;

  // collect to slave
  logic [63:0] res_data;
  logic        res_valid;
  logic        res_pop;
  logic [3:0]  fifo_count;
  logic        fifo_full;

  mul_wb_regs u_regs (
    .clk(clk), .reset(reset),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
    .issue_valid(issue_valid), .issue_a(issue_a), .issue_b(issue_b),
    .issue_op(issue_op), .issue_taken(issue_taken),
    .res_data(res_data), .res_valid(res_valid), .res_pop(res_pop),
    .fifo_count(fifo_count), .fifo_full(fifo_full), .unit_busy(unit_busy)
  );

  mul_dispatch u_dispatch (
    .clk(clk), .reset(reset),
    .issue_valid(issue_valid), .issue_a(issue_a), .issue_b(issue_b),
    .issue_op(issue_op), .unit_busy(unit_busy), .issue_taken(issue_taken),
    .unit_start(unit_start), .unit_a(unit_a), .unit_b(unit_b), .unit_op(unit_op)
  );

  // one multiplier per slot sharing the broadcast operands
  for (genvar i = 0; i < `MUL_NUM_UNITS; i++) begin : g_unit
    mul_iter_unit u_unit (
      .clk(clk), .reset(reset),
      .start(unit_start[i]), .a(unit_a), .b(unit_b), .op(unit_op),
      .taken(unit_taken[i]), .busy(unit_busy[i]), .done(unit_done[i]),
      .result(unit_result[i])
    );
  end

  mul_collect u_collect (
    .clk(clk), .reset(reset),
    .unit_done(unit_done), .unit_result(unit_result), .res_pop(res_pop),
    .unit_taken(unit_taken), .res_data(res_data), .res_valid(res_valid),
    .fifo_count(fifo_count), .fifo_full(fifo_full)
  );

endmodule

`default_nettype wire

// File: verif/tb_mul_top.sv
/*
 * directed testbench for the Wishbone multiply accelerator
 * drives bus reads and writes and checks products against a software model
 */

`timescale 1ns/1ps
`default_nettype none

`include "mul_consts.svh"

module tb_mul_top
  import mul_pkg::*;
;

  localparam int CLK_PERIOD      = 100;
  localparam int NUM_TESTS       = 6;
  localparam int WATCHDOG_CYCLES = 2000;
  // longest normal CMD stall is one full multiply plus drain
  localparam int ACK_LIMIT       = 100;
  localparam int POLL_LIMIT      = 100;
  localparam int STALL_CYCLES    = 200;
  localparam int SOAK_CMDS       = 40;

  logic        clk;
  logic        reset;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [2:0]  wb_adr;
  logic [31:0] wb_dat_w;
  logic [31:0] wb_dat_r;
  logic        wb_ack;

  logic [31:0] lfsr_state;
  logic [63:0] exp_q[$];
  int          errors;
  int          tests;

  mul_top dut (
    .clk(clk), .reset(reset),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ------------------------------
  // stimulus helpers
  // ------------------------------
  // Galois form, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic rand_bit(output logic b);
    b = lfsr_state[0];
    lfsr_state = lfsr_step(lfsr_state);
  endtask

  task automatic rand_word(output logic [31:0] w);
    logic b;
    w = '0;
    for (int i = 0; i < 32; i++) begin
      rand_bit(b);
      w = {w[30:0], b};
    end
  endtask

  // full 64-bit product, operands sign extended for signed ops
  function automatic logic [63:0] ref_product(input logic [31:0] a, input logic [31:0] b,
                                              input logic is_signed);
    logic [63:0] ea;
    logic [63:0] eb;
    ea = is_signed ? {{32{a[31]}}, a} : {32'b0, a};
    eb = is_signed ? {{32{b[31]}}, b} : {32'b0, b};
    return ea * eb;
  endfunction

  task automatic report_mismatch(input string sig, input logic [63:0] exp,
                                 input logic [63:0] act);
    $display("Error: time %0t, %s expected 0x%0h, actual 0x%0h", $time, sig, exp, act);
    errors++;
  endtask

  task automatic apply_reset();
    reset = 1'b1;
    repeat (16) @(negedge clk);
    reset = 1'b0;
  endtask

  // ------------------------------
  // Wishbone master
  // ------------------------------
  task automatic drive_bus(input logic we, input logic [2:0] adr, input logic [31:0] dat);
    @(negedge clk);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = dat;
  endtask

  task automatic release_bus();
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  // sampled on falling edges, away from the DUT clock edge
  task automatic wait_ack(output logic got);
    int waited;
    waited = 0;
    @(negedge clk);
    while (!wb_ack && waited < ACK_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    got = wb_ack;
  endtask

  task automatic wb_write(input logic [2:0] adr, input logic [31:0] dat);
    logic got;
    drive_bus(1'b1, adr, dat);
    wait_ack(got);
    if (!got) begin
      $display("write to address %0d got no ack within %0d cycles", adr, ACK_LIMIT);
      errors++;
    end
    release_bus();
  endtask

  task automatic wb_read(input logic [2:0] adr, output logic [31:0] dat);
    logic got;
    drive_bus(1'b0, adr, 32'b0);
    wait_ack(got);
    dat = wb_dat_r;
    if (!got) begin
      $display("read of address %0d got no ack within %0d cycles", adr, ACK_LIMIT);
      errors++;
    end
    release_bus();
  endtask

  task automatic read_check(input logic [2:0] adr, input logic [31:0] exp, input string sig);
    logic [31:0] act;
    wb_read(adr, act);
    if (act !== exp) begin
      report_mismatch(sig, {32'b0, exp}, {32'b0, act});
    end
  endtask

  // ------------------------------
  // command and result helpers
  // ------------------------------
  task automatic issue_cmd(input logic [31:0] a, input logic [31:0] b, input mul_op_e op);
    wb_write(`MUL_ADR_A, a);
    wb_write(`MUL_ADR_B, b);
    wb_write(`MUL_ADR_CMD, {31'b0, op});
    exp_q.push_back(ref_product(a, b, op == op_mul));
  endtask

  task automatic issue_random(input logic mix_ops);
    logic [31:0] a;
    logic [31:0] b;
    logic        sel;
    rand_word(a);
    rand_word(b);
    sel = 1'b0;
    if (mix_ops) begin
      rand_bit(sel);
    end
    issue_cmd(a, b, sel ? op_mulu : op_mul);
  endtask

  // poll status bits 19:16 until the FIFO holds n results
  task automatic wait_results(input int n);
    logic [31:0] st;
    int          polls;
    polls = 0;
    wb_read(`MUL_ADR_STATUS, st);
    while (int'(st[19:16]) < n && polls < POLL_LIMIT) begin
      wb_read(`MUL_ADR_STATUS, st);
      polls++;
    end
    if (int'(st[19:16]) < n) begin
      $display("FIFO count stuck at %0d while waiting for %0d results", st[19:16], n);
      errors++;
    end
  endtask

  // RES_HI read pops, so the low word goes first
  task automatic check_next_result();
    logic [31:0] lo;
    logic [31:0] hi;
    logic [63:0] exp;
    wait_results(1);
    wb_read(`MUL_ADR_RES_LO, lo);
    wb_read(`MUL_ADR_RES_HI, hi);
    if (exp_q.size() == 0) begin
      $display("a result came back with no command outstanding");
      errors++;
    end else begin
      exp = exp_q.pop_front();
      if (lo !== exp[31:0]) begin
        report_mismatch("RES_LO", {32'b0, exp[31:0]}, {32'b0, lo});
      end
      if (hi !== exp[63:32]) begin
        report_mismatch("RES_HI", {32'b0, exp[63:32]}, {32'b0, hi});
      end
    end
  endtask

  // 8 results in the FIFO and 4 finished units waiting behind it
  task automatic fill_to_full();
    for (int i = 0; i < `MUL_FIFO_DEPTH + `MUL_NUM_UNITS; i++) begin
      issue_random(1'b1);
    end
    wait_results(`MUL_FIFO_DEPTH);
    // count 8, busy 0xF, full and not empty
    read_check(`MUL_ADR_STATUS, 32'h0008_0F03, "STATUS");
  endtask

  // one more CMD write must hang while no unit can drain
  // the master then gives up and the command stays pending in the slave
  task automatic check_cmd_stall(input logic [31:0] a, input logic [31:0] b,
                                 input mul_op_e op);
    logic acked;
    acked = 1'b0;
    wb_write(`MUL_ADR_A, a);
    wb_write(`MUL_ADR_B, b);
    drive_bus(1'b1, `MUL_ADR_CMD, {31'b0, op});
    repeat (STALL_CYCLES) begin
      @(negedge clk);
      if (wb_ack) begin
        acked = 1'b1;
      end
    end
    if (acked) begin
      $display("CMD write was acknowledged while the FIFO was full and all units busy");
      errors++;
    end
    release_bus();
    exp_q.push_back(ref_product(a, b, op == op_mul));
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests++;
    $display("test %s finished at %0t with %0d errors", name, $time, errors - errs_before);
  endtask

  // ------------------------------
  // directed tests
  // ------------------------------
  task automatic register_access();
    int errs;
    errs = errors;
    read_check(`MUL_ADR_STATUS, 32'h0, "STATUS");
    wb_write(`MUL_ADR_A, 32'h1234_5678);
    wb_write(`MUL_ADR_B, 32'h9ABC_DEF0);
    read_check(`MUL_ADR_A, 32'h1234_5678, "A");
    read_check(`MUL_ADR_B, 32'h9ABC_DEF0, "B");
    finish_test("register_access", errs);
  endtask

  task automatic signed_products();
    int errs;
    errs = errors;
    issue_cmd(32'd1234, 32'd5678, op_mul);
    check_next_result();
    issue_cmd(-32'd7, 32'd100000, op_mul);
    check_next_result();
    issue_cmd(-32'd123456, -32'd654321, op_mul);
    check_next_result();
    // most negative squared is 2^62
    issue_cmd(32'h8000_0000, 32'h8000_0000, op_mul);
    check_next_result();
    issue_cmd(32'd0, 32'hDEAD_BEEF, op_mul);
    check_next_result();
    finish_test("signed_products", errs);
  endtask

  task automatic unsigned_products();
    int          errs;
    logic [31:0] a;
    logic [31:0] b;
    errs = errors;
    issue_cmd(32'hFFFF_FFFF, 32'hFFFF_FFFF, op_mulu);
    check_next_result();
    for (int i = 0; i < 4; i++) begin
      rand_word(a);
      rand_word(b);
      issue_cmd(a, b, op_mulu);
      check_next_result();
    end
    // empty FIFO reads zero and must not underflow the count
    read_check(`MUL_ADR_RES_HI, 32'h0, "RES_HI");
    read_check(`MUL_ADR_STATUS, 32'h0, "STATUS");
    finish_test("unsigned_products", errs);
  endtask

  task automatic parallel_order();
    int errs;
    errs = errors;
    for (int i = 0; i < `MUL_NUM_UNITS; i++) begin
      issue_random(1'b1);
    end
    wait_results(`MUL_NUM_UNITS);
    // all drained, so no unit busy
    read_check(`MUL_ADR_STATUS, 32'h0004_0001, "STATUS");
    for (int i = 0; i < `MUL_NUM_UNITS; i++) begin
      check_next_result();
    end
    finish_test("parallel_order", errs);
  endtask

  task automatic back_pressure();
    int          errs;
    logic [31:0] a;
    logic [31:0] b;
    errs = errors;
    fill_to_full();
    rand_word(a);
    rand_word(b);
    check_cmd_stall(a, b, op_mul);
    // the stalled command waits for unit 0, nothing has moved yet
    read_check(`MUL_ADR_STATUS, 32'h0008_0F03, "STATUS");
    // draining frees unit 0, which then takes the pending command
    for (int i = 0; i < `MUL_FIFO_DEPTH + `MUL_NUM_UNITS + 1; i++) begin
      check_next_result();
    end
    read_check(`MUL_ADR_STATUS, 32'h0, "STATUS");
    finish_test("back_pressure", errs);
  endtask

  task automatic random_soak();
    int errs;
    errs = errors;
    for (int i = 0; i < SOAK_CMDS; i++) begin
      issue_random(1'b1);
      check_next_result();
    end
    read_check(`MUL_ADR_STATUS, 32'h0, "STATUS");
    finish_test("random_soak", errs);
  endtask

  // ------------------------------
  // main sequence and watchdog
  // ------------------------------
  initial begin
    reset      = 1'b1;
    wb_cyc     = 1'b0;
    wb_stb     = 1'b0;
    wb_we      = 1'b0;
    wb_adr     = 3'd0;
    wb_dat_w   = 32'b0;
    lfsr_state = 32'd62;
    errors     = 0;
    tests      = 0;
    apply_reset();
    register_access();
    signed_products();
    unsigned_products();
    parallel_order();
    back_pressure();
    random_soak();
    $display("tests run %0d, errors %0d", tests, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  initial begin
    repeat (NUM_TESTS * WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired before all tests finished");
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
+incdir+src
src/mul_pkg.sv
src/mul_wb_regs.sv
src/mul_dispatch.sv
src/mul_iter_unit.sv
src/mul_collect.sv
src/mul_top.sv
verif/tb_mul_top.sv

// File: run.sh
#!/usr/bin/env bash
# compile the multiply accelerator testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
  -f src.f --top-module tb_mul_top --Mdir obj_dir -o tb_mul_top_sim
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

sim_out=$(./obj_dir/tb_mul_top_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

# the run counts as good only if the testbench printed its pass line
if grep -qx "Testbench passed" <<< "$sim_out"; then
  exit 0
fi
echo "pass line not found in simulation output"
exit 1
